// File: src/rvc_pkg.sv
/* rvc fetch shared definitions */

`default_nettype none

package rvc_pkg;

  // major rv32 opcodes produced by the compressed expansion
  typedef enum logic [6:0] {
    OPCODE_LOAD   = 7'h03,
    OPCODE_OPIMM  = 7'h13,
    OPCODE_STORE  = 7'h23,
    OPCODE_OP     = 7'h33,
    OPCODE_LUI    = 7'h37,
    OPCODE_BRANCH = 7'h63,
    OPCODE_JALR   = 7'h67,
    OPCODE_JAL    = 7'h6f
  } opcode_e;

  // fetch controller states, one request in flight at most
  typedef enum logic [1:0] {
    FETCH_IDLE,
    FETCH_WAIT_GNT,
    FETCH_WAIT_RVALID
  } fetch_state_e;

  // first fetch address after reset, word aligned
  localparam logic [31:0] BOOT_ADDR = 32'h0000_0000;

  // word buffer between memory port and aligner
  // pointers wrap by overflow, so keep the depth a power of two
  localparam int FETCH_BUF_DEPTH = 4;
  localparam int FETCH_BUF_AW    = $clog2(FETCH_BUF_DEPTH);

endpackage

`default_nettype wire

// File: src/compressed_decoder.sv
/* rvc to rv32 expansion */

`timescale 1ns/1ps
`default_nettype none

module compressed_decoder (
  input  logic [31:0] instr_i,
  output logic [31:0] instr_o,
  output logic        is_compressed_o,
  output logic        illegal_instr_o
);

  import rvc_pkg::*;

  // full register fields
  logic [4:0]  rd;
  logic [4:0]  rs2;
  // three-bit register fields, x8..x15
  logic [4:0]  rs1_p;
  logic [4:0]  rs2_p;
  // sign-extended 6-bit immediate of the ci format
  logic [11:0] imm6;
  // jump and branch offsets, bit 0 is implicit
  logic [11:1] j_off;
  logic [8:1]  b_off;
  // funct3 of the c.sub/xor/or/and group
  logic [2:0]  arith_f3;

  assign rd    = instr_i[11:7];
  assign rs2   = instr_i[6:2];
  assign rs1_p = {2'b01, instr_i[9:7]};
  // also the rd' slot of c.lw and c.addi4spn
  assign rs2_p = {2'b01, instr_i[4:2]};
  assign imm6  = {{6{instr_i[12]}}, instr_i[12], instr_i[6:2]};

  // cj format scrambles offset[11|4|9:8|10|6|7|3:1|5]
  assign j_off = {instr_i[12], instr_i[8], instr_i[10:9], instr_i[6], instr_i[7],
                  instr_i[2], instr_i[11], instr_i[5:3]};
  // cb format scrambles offset[8|4:3] and offset[7:6|2:1|5]
  assign b_off = {instr_i[12], instr_i[6:5], instr_i[2], instr_i[11:10], instr_i[4:3]};

  // 00 sub, 01 xor, 10 or, 11 and
  assign arith_f3 = (instr_i[6:5] == 2'b00) ? 3'b000 :
                    {1'b1, instr_i[6], instr_i[6] & instr_i[5]};

  always_comb begin
    // 32-bit words fall through unchanged
    instr_o         = instr_i;
    illegal_instr_o = 1'b0;

    unique case (instr_i[1:0])
      //////////////////////////////////////////////////
      // quadrant 0, stack and register-based memory ops
      //////////////////////////////////////////////////
      2'b00: begin
        unique case (instr_i[15:13])
          3'b000: begin
            // c.addi4spn, addi rd', x2, nzuimm
            instr_o = {2'b00, instr_i[10:7], instr_i[12:11], instr_i[5], instr_i[6], 2'b00,
                       5'd2, 3'b000, rs2_p, OPCODE_OPIMM};
            // zero immediate is reserved, this includes the all-zero word
            illegal_instr_o = (instr_i[12:5] == 8'd0);
          end
          3'b010: begin
            // c.lw, word offset scaled by 4
            instr_o = {5'b0, instr_i[5], instr_i[12:10], instr_i[6], 2'b00,
                       rs1_p, 3'b010, rs2_p, OPCODE_LOAD};
          end
          3'b110: begin
            // c.sw, immediate split across the s format
            instr_o = {5'b0, instr_i[5], instr_i[12], rs2_p, rs1_p, 3'b010,
                       instr_i[11:10], instr_i[6], 2'b00, OPCODE_STORE};
          end
          default: begin
            // funct 100 is reserved, the rest are float or rv64
            illegal_instr_o = 1'b1;
          end
        endcase
      end

      //////////////////////////////////////////////////
      // quadrant 1, immediates, alu and control flow
      //////////////////////////////////////////////////
      2'b01: begin
        unique case (instr_i[15:13])
          3'b000: begin
            // c.addi, and c.nop when rd is zero
            instr_o = {imm6, rd, 3'b000, rd, OPCODE_OPIMM};
          end
          3'b001, 3'b101: begin
            // c.jal links x1, c.j links x0
            instr_o = {j_off[11], j_off[10:1], j_off[11], {8{j_off[11]}},
                       4'b0000, ~instr_i[15], OPCODE_JAL};
          end
          3'b010: begin
            // c.li, addi rd, x0, imm
            instr_o = {imm6, 5'd0, 3'b000, rd, OPCODE_OPIMM};
            illegal_instr_o = (rd == 5'd0);
          end
          3'b011: begin
            if (rd == 5'd2) begin
              // c.addi16sp, nzimm[9:4] scaled by 16
              instr_o = {{3{instr_i[12]}}, instr_i[4:3], instr_i[5], instr_i[2], instr_i[6],
                         4'b0000, 5'd2, 3'b000, 5'd2, OPCODE_OPIMM};
            end else begin
              // c.lui, imm lands in bits 17:12
              instr_o = {{14{instr_i[12]}}, instr_i[12], instr_i[6:2], rd, OPCODE_LUI};
            end
            illegal_instr_o = ({instr_i[12], instr_i[6:2]} == 6'd0);
          end
          3'b100: begin
            unique case (instr_i[11:10])
              2'b00, 2'b01: begin
                // c.srli and c.srai, bit 10 picks the arithmetic shift
                instr_o = {1'b0, instr_i[10], 5'b0, rs2, rs1_p, 3'b101, rs1_p, OPCODE_OPIMM};
                // shamt[5] set is rv64 only
                illegal_instr_o = instr_i[12] || (rs2 == 5'd0);
              end
              2'b10: begin
                // c.andi
                instr_o = {imm6, rs1_p, 3'b111, rs1_p, OPCODE_OPIMM};
              end
              default: begin
                if (instr_i[12]) begin
                  // c.subw, c.addw and two reserved slots
                  illegal_instr_o = 1'b1;
                end else begin
                  // register-register alu, sub sets funct7 bit 5
                  instr_o = {1'b0, (instr_i[6:5] == 2'b00), 5'b0, rs2_p, rs1_p,
                             arith_f3, rs1_p, OPCODE_OP};
                end
              end
            endcase
          end
          default: begin
            // c.beqz and c.bnez, funct3 bit 0 from instr bit 13
            instr_o = {{4{b_off[8]}}, b_off[7:5], 5'd0, rs1_p, 2'b00, instr_i[13],
                       b_off[4:1], b_off[8], OPCODE_BRANCH};
          end
        endcase
      end

      //////////////////////////////////////////////////
      // quadrant 2, sp-relative and full-register ops
      //////////////////////////////////////////////////
      2'b10: begin
        unique case (instr_i[15:13])
          3'b000: begin
            // c.slli
            instr_o = {7'b0, rs2, rd, 3'b001, rd, OPCODE_OPIMM};
            illegal_instr_o = (rd == 5'd0) || instr_i[12] || (rs2 == 5'd0);
          end
          3'b010: begin
            // c.lwsp
            instr_o = {4'b0, instr_i[3:2], instr_i[12], instr_i[6:4], 2'b00,
                       5'd2, 3'b010, rd, OPCODE_LOAD};
            illegal_instr_o = (rd == 5'd0);
          end
          3'b100: begin
            if (!instr_i[12]) begin
              if (rs2 == 5'd0) begin
                // c.jr, rs1 of zero is reserved
                instr_o = {12'b0, rd, 3'b000, 5'd0, OPCODE_JALR};
                illegal_instr_o = (rd == 5'd0);
              end else begin
                // c.mv
                instr_o = {7'b0, rs2, 5'd0, 3'b000, rd, OPCODE_OP};
              end
            end else if (rs2 == 5'd0) begin
              if (rd == 5'd0) begin
                // c.ebreak
                instr_o = 32'h0010_0073;
              end else begin
                // c.jalr
                instr_o = {12'b0, rd, 3'b000, 5'd1, OPCODE_JALR};
              end
            end else begin
              // c.add
              instr_o = {7'b0, rs2, rd, 3'b000, rd, OPCODE_OP};
              illegal_instr_o = (rd == 5'd0);
            end
          end
          3'b110: begin
            // c.swsp
            instr_o = {4'b0, instr_i[8:7], instr_i[12], rs2, 5'd2, 3'b010,
                       instr_i[11:9], 2'b00, OPCODE_STORE};
          end
          default: begin
            illegal_instr_o = 1'b1;
          end
        endcase
      end

      default: begin
        // low bits 11, already an rv32 instruction
      end
    endcase
  end

  assign is_compressed_o = (instr_i[1:0] != 2'b11);

endmodule

`default_nettype wire

// File: src/fetch_ctrl.sv
/* instruction fetch controller */

`timescale 1ns/1ps
`default_nettype none

module fetch_ctrl (
  input  logic                           clk,
  input  logic                           rst_i,
  input  logic                           branch_i,
  input  logic [31:0]                    branch_addr_i,
  input  logic                           instr_gnt_i,
  input  logic                           instr_rvalid_i,
  input  logic [rvc_pkg::FETCH_BUF_AW:0] buf_count_i,
  output logic                           instr_req_o,
  output logic [31:0]                    instr_addr_o,
  output logic                           buf_push_o,
  output logic                           buf_flush_o
);

  import rvc_pkg::*;

  fetch_state_e state_q;
  fetch_state_e state_d;
  // address of the pending or next request
  logic [31:0]  addr_q;
  // target kept while a request waits for grant
  logic [31:0]  redir_q;
  // response in flight belongs to a flushed stream
  logic         discard_q;
  logic [31:0]  target_word;
  logic         has_space;

  assign target_word = {branch_addr_i[31:2], 2'b00};
  // the word of the next request needs a free slot
  assign has_space = (buf_count_i < (FETCH_BUF_AW + 1)'(FETCH_BUF_DEPTH));

  //////////////////////////////////////////////////
  // request fsm
  //////////////////////////////////////////////////
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      FETCH_IDLE: begin
        // a branch empties the buffer, so there is room
        if (has_space || branch_i) begin
          state_d = FETCH_WAIT_GNT;
        end
      end
      FETCH_WAIT_GNT: begin
        if (instr_gnt_i) begin
          state_d = FETCH_WAIT_RVALID;
        end
      end
      FETCH_WAIT_RVALID: begin
        if (instr_rvalid_i) begin
          state_d = FETCH_IDLE;
        end
      end
      default: state_d = FETCH_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_q   <= FETCH_IDLE;
      addr_q    <= BOOT_ADDR;
      discard_q <= 1'b0;
    end else begin
      state_q <= state_d;
      // the address may only move once the request is accepted
      if (state_q == FETCH_WAIT_GNT && instr_gnt_i) begin
        if (branch_i) begin
          addr_q <= target_word;
        end else if (discard_q) begin
          addr_q <= redir_q;
        end else begin
          addr_q <= addr_q + 32'd4;
        end
      end else if (branch_i && state_q != FETCH_WAIT_GNT) begin
        addr_q <= target_word;
      end
      // a response arriving with the branch is dropped at the push
      if (state_q == FETCH_WAIT_RVALID && instr_rvalid_i) begin
        discard_q <= 1'b0;
      end else if (branch_i && state_q != FETCH_IDLE) begin
        discard_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (branch_i) begin
      redir_q <= target_word;
    end
  end

  assign instr_req_o  = (state_q == FETCH_WAIT_GNT);
  assign instr_addr_o = addr_q;
  assign buf_flush_o  = branch_i;
  assign buf_push_o   = (state_q == FETCH_WAIT_RVALID) && instr_rvalid_i &&
                        !discard_q && !branch_i;

  // memory port holds the request until it is granted
  a_addr_stable : assert property (@(posedge clk) disable iff (rst_i)
    instr_req_o && !instr_gnt_i |=> instr_req_o && $stable(instr_addr_o));

  a_no_rvalid_idle : assert property (@(posedge clk) disable iff (rst_i)
    state_q == FETCH_IDLE |-> !instr_rvalid_i);

  // space was reserved when the request went out
  a_push_space : assert property (@(posedge clk) disable iff (rst_i)
    buf_push_o |-> has_space);

endmodule

`default_nettype wire

// File: src/fetch_buffer.sv
/* fetched word FIFO */

`timescale 1ns/1ps
`default_nettype none

module fetch_buffer (
  input  logic                           clk,
  input  logic                           rst_i,
  input  logic                           push_i,
  input  logic                           pop_i,
  input  logic                           flush_i,
  input  logic [31:0]                    wdata_i,
  output logic [31:0]                    rdata_o,
  output logic                           empty_o,
  output logic [rvc_pkg::FETCH_BUF_AW:0] count_o
);

  import rvc_pkg::*;

  logic [31:0]             mem_q [FETCH_BUF_DEPTH];
  logic [FETCH_BUF_AW-1:0] rd_ptr_q;
  logic [FETCH_BUF_AW-1:0] wr_ptr_q;
  // one bit wider than the pointers to tell full from empty
  logic [FETCH_BUF_AW:0]   count_q;

  always_ff @(posedge clk) begin
    if (rst_i || flush_i) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      // simultaneous push and pop leave the count alone
      if (push_i && !pop_i) begin
        count_q <= count_q + 1'b1;
      end else if (pop_i && !push_i) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // storage
  always_ff @(posedge clk) begin
    if (push_i && !flush_i) begin
      mem_q[wr_ptr_q] <= wdata_i;
    end
  end

  // head word, valid only while not empty
  assign rdata_o = mem_q[rd_ptr_q];
  assign empty_o = (count_q == '0);
  assign count_o = count_q;

  a_no_underflow : assert property (@(posedge clk) disable iff (rst_i || flush_i)
    pop_i |-> !empty_o);

  a_no_overflow : assert property (@(posedge clk) disable iff (rst_i || flush_i)
    push_i && (count_q == (FETCH_BUF_AW + 1)'(FETCH_BUF_DEPTH)) |-> pop_i);

endmodule

`default_nettype wire

// File: src/instr_aligner.sv
/* halfword instruction aligner */

`timescale 1ns/1ps
`default_nettype none

module instr_aligner (
  input  logic        clk,
  input  logic        rst_i,
  input  logic        branch_i,
  input  logic [31:0] branch_addr_i,
  input  logic [31:0] buf_rdata_i,
  input  logic        buf_empty_i,
  output logic        buf_pop_o,
  input  logic        id_ready_i,
  output logic        aligned_valid_o,
  output logic [31:0] aligned_instr_o,
  output logic [31:0] aligned_pc_o
);

  import rvc_pkg::*;

  logic [31:0] pc_q;
  // low half of the head word already consumed
  logic        half_used_q;
  // upper half of a word that started a 32-bit instruction
  logic        partial_valid_q;
  logic [15:0] partial_q;
  logic [15:0] half;
  logic        is_c;
  logic        save;
  logic        consume;

  // next unconsumed halfword of the head word
  assign half = half_used_q ? buf_rdata_i[31:16] : buf_rdata_i[15:0];

  //////////////////////////////////////////////////
  // instruction assembly
  //////////////////////////////////////////////////
  always_comb begin
    aligned_valid_o = 1'b0;
    aligned_instr_o = {16'b0, half};
    save            = 1'b0;
    if (!buf_empty_i) begin
      if (partial_valid_q) begin
        // straddling instruction, high half from the new head
        aligned_valid_o = 1'b1;
        aligned_instr_o = {buf_rdata_i[15:0], partial_q};
      end else if (half[1:0] != 2'b11) begin
        // compressed, upper half stays zero
        aligned_valid_o = 1'b1;
      end else if (!half_used_q) begin
        // aligned 32-bit instruction fills the word
        aligned_valid_o = 1'b1;
        aligned_instr_o = buf_rdata_i;
      end else begin
        // 32-bit start in the upper half, park it and move on
        save = 1'b1;
      end
    end
  end

  assign is_c    = (aligned_instr_o[1:0] != 2'b11);
  assign consume = aligned_valid_o && id_ready_i && !branch_i;

  // pop once both halves of the head word are used up
  assign buf_pop_o = !branch_i &&
                     (save || (consume && !partial_valid_q && (half_used_q || !is_c)));

  always_ff @(posedge clk) begin
    if (rst_i) begin
      pc_q            <= BOOT_ADDR;
      half_used_q     <= 1'b0;
      partial_valid_q <= 1'b0;
    end else if (branch_i) begin
      // target in the upper half skips the low one
      pc_q            <= branch_addr_i;
      half_used_q     <= branch_addr_i[1];
      partial_valid_q <= 1'b0;
    end else if (save) begin
      half_used_q     <= 1'b0;
      partial_valid_q <= 1'b1;
    end else if (consume) begin
      pc_q            <= pc_q + (is_c ? 32'd2 : 32'd4);
      // straddle or low compressed leaves the upper half pending
      half_used_q     <= partial_valid_q || (is_c && !half_used_q);
      partial_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (save) begin
      partial_q <= half;
    end
  end

  assign aligned_pc_o = pc_q;

  // branch targets from decode must be halfword aligned
  a_pc_even : assert property (@(posedge clk) disable iff (rst_i)
    !aligned_pc_o[0]);

endmodule

`default_nettype wire

// File: src/if_stage.sv
/* instruction fetch stage */

`timescale 1ns/1ps
`default_nettype none

module if_stage (
  input  logic        clk,
  input  logic        rst_i,
  // instruction memory
  output logic        instr_req_o,
  output logic [31:0] instr_addr_o,
  input  logic        instr_gnt_i,
  input  logic        instr_rvalid_i,
  input  logic [31:0] instr_rdata_i,
  // decode stage
  input  logic        id_ready_i,
  input  logic        branch_i,
  input  logic [31:0] branch_addr_i,
  output logic        instr_valid_o,
  output logic [31:0] instr_rdata_o,
  output logic        is_compressed_o,
  output logic        illegal_c_insn_o,
  output logic [31:0] pc_id_o
);

  import rvc_pkg::*;

  logic                  buf_push;
  logic                  buf_pop;
  logic                  buf_flush;
  logic                  buf_empty;
  logic [31:0]           buf_rdata;
  logic [FETCH_BUF_AW:0] buf_count;
  logic [31:0]           aligned_instr;

  fetch_ctrl u_fetch_ctrl (
    .clk            (clk),
    .rst_i          (rst_i),
    .branch_i       (branch_i),
    .branch_addr_i  (branch_addr_i),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i),
    .buf_count_i    (buf_count),
    .instr_req_o    (instr_req_o),
    .instr_addr_o   (instr_addr_o),
    .buf_push_o     (buf_push),
    .buf_flush_o    (buf_flush)
  );

  // response words go straight into the buffer
  fetch_buffer u_fetch_buffer (
    .clk     (clk),
    .rst_i   (rst_i),
    .push_i  (buf_push),
    .pop_i   (buf_pop),
    .flush_i (buf_flush),
    .wdata_i (instr_rdata_i),
    .rdata_o (buf_rdata),
    .empty_o (buf_empty),
    .count_o (buf_count)
  );

  instr_aligner u_instr_aligner (
    .clk             (clk),
    .rst_i           (rst_i),
    .branch_i        (branch_i),
    .branch_addr_i   (branch_addr_i),
    .buf_rdata_i     (buf_rdata),
    .buf_empty_i     (buf_empty),
    .buf_pop_o       (buf_pop),
    .id_ready_i      (id_ready_i),
    .aligned_valid_o (instr_valid_o),
    .aligned_instr_o (aligned_instr),
    .aligned_pc_o    (pc_id_o)
  );

  // expansion is combinational, zero added latency
  compressed_decoder u_compressed_decoder (
    .instr_i         (aligned_instr),
    .instr_o         (instr_rdata_o),
    .is_compressed_o (is_compressed_o),
    .illegal_instr_o (illegal_c_insn_o)
  );

endmodule

`default_nettype wire

// File: dv/tb_instr_mem.sv
/* instruction memory model */

`timescale 1ns/1ps
`default_nettype none

module tb_instr_mem (
  input  logic        clk,
  input  logic        rst_i,
  input  logic        req_i,
  input  logic [31:0] addr_i,
  output logic        gnt_o,
  output logic        rvalid_o,
  output logic [31:0] rdata_o
);

  // 1 KiB image, addresses wrap on bit 10
  localparam int IMG_HW = 512;
  // halfwords of the fixed compressed section at the start of the image
  localparam int FIX_N  = 14;

  integer      seed;
  logic [15:0] hw [IMG_HW];
  logic [15:0] fix_hw [FIX_N];
  logic [31:0] fix_exp [FIX_N];
  logic        fix_ill [FIX_N];
  int          gnt_wait;
  int          rv_wait;
  logic        pending;
  logic [31:0] paddr;
  int          idx;
  logic [31:0] r;

  task automatic set_fix(input int i, input logic [15:0] c, input logic [31:0] e,
                         input logic ill);
    fix_hw[i]  = c;
    fix_exp[i] = e;
    fix_ill[i] = ill;
  endtask

  initial begin
    seed     = 32'h7648_4c37;
    gnt_o    = 1'b0;
    rvalid_o = 1'b0;
    rdata_o  = '0;
    pending  = 1'b0;
    gnt_wait = 0;
    rv_wait  = 0;
    // known encodings, expected rv32 form, illegal flag
    set_fix(0,  16'h0001, 32'h0000_0013, 1'b0);  // c.nop
    set_fix(1,  16'h4515, 32'h0050_0513, 1'b0);  // c.li x10, 5
    set_fix(2,  16'h4015, 32'h0000_0000, 1'b1);  // c.li with rd zero
    set_fix(3,  16'h9c25, 32'h0000_0000, 1'b1);  // c.addw, rv64 only
    set_fix(4,  16'h8000, 32'h0000_0000, 1'b1);  // quadrant 0 funct 100
    set_fix(5,  16'h85b2, 32'h00c0_05b3, 1'b0);  // c.mv x11, x12
    set_fix(6,  16'h952e, 32'h00b5_0533, 1'b0);  // c.add x10, x11
    set_fix(7,  16'h157d, 32'hfff5_0513, 1'b0);  // c.addi x10, -1
    set_fix(8,  16'h4044, 32'h0044_2483, 1'b0);  // c.lw x9, 4(x8)
    set_fix(9,  16'h050a, 32'h0025_1513, 1'b0);  // c.slli x10, 2
    set_fix(10, 16'h4082, 32'h0001_2083, 1'b0);  // c.lwsp x1, 0(sp)
    set_fix(11, 16'h8082, 32'h0000_8067, 1'b0);  // c.jr x1
    set_fix(12, 16'h8c05, 32'h4094_0433, 1'b0);  // c.sub x8, x9
    set_fix(13, 16'h9002, 32'h0010_0073, 1'b0);  // c.ebreak
    for (int i = 0; i < FIX_N; i++) begin
      hw[i] = fix_hw[i];
    end
    // random mix of 16 and 32 bit instructions after the fixed part
    idx = FIX_N;
    while (idx < IMG_HW) begin
      r = $random(seed);
      if (r[0] && idx < IMG_HW - 1) begin
        r = $random(seed);
        hw[idx]     = {r[15:2], 2'b11};
        hw[idx + 1] = r[31:16];
        idx         = idx + 2;
      end else begin
        r = $random(seed);
        hw[idx] = {r[15:2], (r[1:0] == 2'b11) ? 2'b01 : r[1:0]};
        idx     = idx + 1;
      end
    end
  end

  ////////////////////////////////////////////////////
  // bus timing, random grant and response delays
  ////////////////////////////////////////////////////
  always @(negedge clk) begin
    gnt_o    <= 1'b0;
    rvalid_o <= 1'b0;
    if (rst_i) begin
      pending  = 1'b0;
      gnt_wait = 0;
    end else if (pending) begin
      if (rv_wait == 0) begin
        rvalid_o <= 1'b1;
        rdata_o  <= {hw[{paddr[9:2], 1'b1}], hw[{paddr[9:2], 1'b0}]};
        pending  = 1'b0;
      end else begin
        rv_wait = rv_wait - 1;
      end
    end else if (req_i) begin
      if (gnt_wait == 0) begin
        gnt_o    <= 1'b1;
        paddr    = addr_i;
        pending  = 1'b1;
        r        = $random(seed);
        rv_wait  = r[1:0] % 3;
        gnt_wait = r[3:2] % 3;
      end else begin
        gnt_wait = gnt_wait - 1;
      end
    end
  end

endmodule

`default_nettype wire

// File: dv/tb_if_stage.sv
/* fetch stage testbench */

`timescale 1ns/1ps
`default_nettype none

module tb_if_stage;

  import rvc_pkg::*;

  logic        clk;
  logic        rst_i;
  logic        instr_req_o;
  logic [31:0] instr_addr_o;
  logic        instr_gnt_i;
  logic        instr_rvalid_i;
  logic [31:0] instr_rdata_i;
  logic        id_ready_i;
  logic        branch_i;
  logic [31:0] branch_addr_i;
  logic        instr_valid_o;
  logic [31:0] instr_rdata_o;
  logic        is_compressed_o;
  logic        illegal_c_insn_o;
  logic [31:0] pc_id_o;

  integer      seed;
  int          assert_err;
  int          timeout_err;
  int          stall_left;
  int          consumed;
  int          goal;
  int          t;
  logic [31:0] r;
  // reference parse pointer and bus bookkeeping
  logic [31:0] ref_pc;
  logic        outstanding;
  logic        seen_req;
  logic        fire;
  logic [15:0] h0;
  logic [15:0] h1;
  logic        exp_c;
  logic        in_fix;

  if_stage i_if_stage (.*);

  tb_instr_mem i_mem (
    .clk      (clk),
    .rst_i    (rst_i),
    .req_i    (instr_req_o),
    .addr_i   (instr_addr_o),
    .gnt_o    (instr_gnt_i),
    .rvalid_o (instr_rvalid_i),
    .rdata_o  (instr_rdata_i)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // expected halfwords straight from the image
  always_comb begin
    h0     = i_mem.hw[ref_pc[9:1]];
    h1     = i_mem.hw[ref_pc[9:1] + 9'd1];
    exp_c  = (h0[1:0] != 2'b11);
    in_fix = (ref_pc < 32'd28);
  end

  assign fire = instr_valid_o && id_ready_i && !branch_i;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      ref_pc      <= BOOT_ADDR;
      outstanding <= 1'b0;
      seen_req    <= 1'b0;
      consumed    <= 0;
    end else begin
      if (instr_req_o) begin
        seen_req <= 1'b1;
      end
      if (instr_req_o && instr_gnt_i) begin
        outstanding <= 1'b1;
      end else if (instr_rvalid_i) begin
        outstanding <= 1'b0;
      end
      // branch restarts the parse at the target
      if (branch_i) begin
        ref_pc <= branch_addr_i;
      end else if (fire) begin
        ref_pc   <= ref_pc + (exp_c ? 32'd2 : 32'd4);
        consumed <= consumed + 1;
      end
    end
  end

  ////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////
  a_reset_quiet : assert property (@(posedge clk) rst_i |=> !instr_req_o && !instr_valid_o)
    else begin
      assert_err++;
      $display("Error %0t: request or valid high right after reset", $time);
    end

  a_boot_addr : assert property (@(posedge clk) disable iff (rst_i)
    instr_req_o && !seen_req |-> instr_addr_o == BOOT_ADDR)
    else begin
      assert_err++;
      $display("Error %0t: instr_addr_o got %h expected %h", $time,
               $sampled(instr_addr_o), BOOT_ADDR);
    end

  // no new request until the granted word has come back
  a_one_outstanding : assert property (@(posedge clk) disable iff (rst_i)
    instr_req_o |-> !outstanding)
    else begin
      assert_err++;
      $display("Error %0t: request raised while another is outstanding", $time);
    end

  a_pc : assert property (@(posedge clk) disable iff (rst_i) fire |-> pc_id_o == ref_pc)
    else begin
      assert_err++;
      $display("Error %0t: pc_id_o got %h expected %h", $time,
               $sampled(pc_id_o), $sampled(ref_pc));
    end

  a_is_c : assert property (@(posedge clk) disable iff (rst_i)
    fire |-> is_compressed_o == exp_c)
    else begin
      assert_err++;
      $display("Error %0t: is_compressed_o got %b expected %b", $time,
               $sampled(is_compressed_o), $sampled(exp_c));
    end

  // 32-bit words come through untouched, straddling ones too
  a_word32 : assert property (@(posedge clk) disable iff (rst_i)
    fire && !exp_c |-> instr_rdata_o == {h1, h0} && !illegal_c_insn_o)
    else begin
      assert_err++;
      $display("Error %0t: instr_rdata_o got %h expected %h", $time,
               $sampled(instr_rdata_o), $sampled({h1, h0}));
    end

  a_fix_illegal : assert property (@(posedge clk) disable iff (rst_i)
    fire && in_fix |-> illegal_c_insn_o == i_mem.fix_ill[ref_pc[4:1]])
    else begin
      assert_err++;
      $display("Error %0t: illegal_c_insn_o got %b expected %b", $time,
               $sampled(illegal_c_insn_o), i_mem.fix_ill[$sampled(ref_pc[4:1])]);
    end

  a_fix_expand : assert property (@(posedge clk) disable iff (rst_i)
    fire && in_fix && !i_mem.fix_ill[ref_pc[4:1]] |->
    instr_rdata_o == i_mem.fix_exp[ref_pc[4:1]])
    else begin
      assert_err++;
      $display("Error %0t: instr_rdata_o got %h expected %h", $time,
               $sampled(instr_rdata_o), i_mem.fix_exp[$sampled(ref_pc[4:1])]);
    end

  // decode-side outputs hold while decode is stalled
  a_stall_hold : assert property (@(posedge clk) disable iff (rst_i)
    instr_valid_o && !id_ready_i && !branch_i |=>
    instr_valid_o && $stable(instr_rdata_o) && $stable(pc_id_o))
    else begin
      assert_err++;
      $display("Error %0t: stall hold pc_id_o %h was %h, instr_rdata_o %h was %h", $time,
               $sampled(pc_id_o), $past(pc_id_o), $sampled(instr_rdata_o),
               $past(instr_rdata_o));
    end

  ////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////
  // random stall spans on the ready level
  task automatic drive_ready();
    if (stall_left > 0) begin
      id_ready_i = 1'b0;
      stall_left--;
    end else begin
      id_ready_i = 1'b1;
      r = $random(seed);
      if (r[2:0] == 3'd0) begin
        stall_left = 1 + r[5:3] % 5;
      end
    end
  endtask

  task automatic run_until(input int n);
    goal = consumed + n;
    t    = 0;
    while (consumed < goal && t < 2000) begin
      @(negedge clk);
      drive_ready();
      t++;
    end
    if (consumed < goal) begin
      timeout_err++;
      $display("timeout while waiting for instructions to be consumed");
    end
  endtask

  // branch while a fetch request is in flight
  task automatic redirect(input logic [31:0] target);
    t = 0;
    while (!(outstanding || instr_req_o) && t < 200) begin
      @(negedge clk);
      drive_ready();
      t++;
    end
    if (!(outstanding || instr_req_o)) begin
      timeout_err++;
      $display("timeout while waiting for a request to branch over");
    end
    branch_i      = 1'b1;
    branch_addr_i = target;
    @(negedge clk);
    branch_i = 1'b0;
  endtask

  initial begin
    seed          = 32'h7648_4c37;
    assert_err    = 0;
    timeout_err   = 0;
    stall_left    = 0;
    rst_i         = 1'b1;
    id_ready_i    = 1'b0;
    branch_i      = 1'b0;
    branch_addr_i = '0;
    repeat (8) @(negedge clk);
    rst_i = 1'b0;
    for (int p = 0; p < 8; p++) begin
      r = $random(seed);
      run_until(20 + r[4:0]);
      // odd passes land on the upper halfword
      redirect({23'd0, r[15:9], 2'b00} + ((p % 2 == 1) ? 32'd2 : 32'd0));
    end
    run_until(40);
    repeat (4) @(negedge clk);
    $display("errors: %0d assertion, %0d timeout, %0d instructions consumed",
             assert_err, timeout_err, consumed);
    if (assert_err == 0 && timeout_err == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: all.f
src/rvc_pkg.sv
src/compressed_decoder.sv
src/fetch_ctrl.sv
src/fetch_buffer.sv
src/instr_aligner.sv
src/if_stage.sv
dv/tb_instr_mem.sv
dv/tb_if_stage.sv

// File: Makefile
TOP = tb_if_stage

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f all.f --top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "TEST PASSED"

clean:
	rm -rf obj_dir
